// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = STATUS: FAIL

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_miss_ctrl.sv
icache_fetch_out.sv
icache_top.sv
icache_tb_mem.sv
icache_tb.sv

// File: icache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_array (
    input  logic                           clk,
    input  logic                           stall,
    input  logic [icache_pkg::INDEX_W-1:0] index_s1,
    input  logic [icache_pkg::INDEX_W-1:0] index_s2,
    input  logic                           we_way0,
    input  logic                           we_way1,
    input  icache_pkg::line_t              ret_data,
    output icache_pkg::line_t              line_way0_s2,
    output icache_pkg::line_t              line_way1_s2
);

    import icache_pkg::*;

    logic [INDEX_W-1:0] read_addr;
    logic [1:0]         we;
    logic [1:0]         collide;
    logic [1:0]         collide_q;
    line_t              bank_q [2];
    line_t              refill_q;

    // a stalled request keeps rereading its own set
    assign read_addr = stall ? index_s2 : index_s1;
    assign we        = {we_way1, we_way0};

    //////////////////////////////////////////////////////////////////////
    // eight word banks per way
    //////////////////////////////////////////////////////////////////////

    generate
        for (genvar w = 0; w < 2; w++) begin : g_way
            // read and write on the same set in one cycle
            assign collide[w] = we[w] && (index_s2 == read_addr);

            for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
                logic [WORD_W-1:0] mem [NUM_SETS];
                logic [WORD_W-1:0] rd_q;

                // write port at the refill set
                always_ff @(posedge clk) begin
                    if (we[w]) begin
                        mem[index_s2] <= ret_data.words[b];
                    end
                end

                // read port off during a collision
                always_ff @(posedge clk) begin
                    if (!collide[w]) begin
                        rd_q <= mem[read_addr];
                    end
                end

                assign bank_q[w].words[b] = rd_q;
            end
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // collision bypass
    //////////////////////////////////////////////////////////////////////

    // copy of the line just written, served in place of the bank read
    always_ff @(posedge clk) begin
        collide_q <= collide;
        if (we_way0 || we_way1) begin
            refill_q <= ret_data;
        end
    end

    assign line_way0_s2 = collide_q[0] ? refill_q : bank_q[0];
    assign line_way1_s2 = collide_q[1] ? refill_q : bank_q[1];

endmodule

`default_nettype wire

// File: icache_fetch_out.sv
`timescale 1ns/100ps
`default_nettype none

module icache_fetch_out (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              valid_s2,
    input  logic                              uncached_s2,
    input  logic                              hit_s2,
    input  logic                              hit_way0_s2,
    input  logic                              hit_way1_s2,
    input  logic [icache_pkg::WORD_SEL_W-1:0] word_s2,
    input  logic [icache_pkg::ADDR_W-1:0]     vaddr1_s2,
    input  logic [icache_pkg::ADDR_W-1:0]     vaddr2_s2,
    input  icache_pkg::line_t                 line_way0_s2,
    input  icache_pkg::line_t                 line_way1_s2,
    input  logic                              ret_valid,
    input  icache_pkg::line_t                 ret_data,
    output logic                              data_ok1,
    output logic                              data_ok2,
    output logic [icache_pkg::WORD_W-1:0]     rdata1,
    output logic [icache_pkg::WORD_W-1:0]     rdata2,
    output logic [icache_pkg::ADDR_W-1:0]     raddr1,
    output logic [icache_pkg::ADDR_W-1:0]     raddr2
);

    import icache_pkg::*;

    logic                  refill;
    logic                  ok1_s2;
    logic                  ok2_s2;
    line_t                 sel_line;
    logic [WORD_SEL_W-1:0] word2_sel;
    logic [WORD_W-1:0]     rdata1_s2;
    logic [WORD_W-1:0]     rdata2_s2;

    // return pulse completes the pending miss, cached or not
    assign refill = valid_s2 && !hit_s2 && ret_valid;
    assign ok1_s2 = hit_s2 || refill;

    // no second word at the end of a line or on an uncached read
    assign ok2_s2 = ok1_s2 && !uncached_s2
                    && (word_s2 != WORD_SEL_W'(WORDS_PER_LINE - 1));

    //////////////////////////////////////////////////////////////////////
    // way and word select
    //////////////////////////////////////////////////////////////////////

    // refill data forwarded straight from the bus
    assign sel_line.flat = refill ? ret_data.flat
                         : ({LINE_W{hit_way0_s2}} & line_way0_s2.flat)
                         | ({LINE_W{hit_way1_s2}} & line_way1_s2.flat);

    assign word2_sel = word_s2 + 1'b1;

    // single-word return sits in the low bits
    assign rdata1_s2 = uncached_s2 ? ret_data.words[0] : sel_line.words[word_s2];
    // second word zero when it starts a new line
    assign rdata2_s2 = (vaddr2_s2[OFFSET_W-1:0] == '0) ? '0 : sel_line.words[word2_sel];

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    // flush drops whatever is in flight
    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            data_ok1 <= 1'b0;
            data_ok2 <= 1'b0;
        end else begin
            data_ok1 <= ok1_s2;
            data_ok2 <= ok2_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (ok1_s2) begin
            rdata1 <= rdata1_s2;
            rdata2 <= rdata2_s2;
            raddr1 <= vaddr1_s2;
            raddr2 <= vaddr2_s2;
        end
    end

    // second word rides with the first and never past the line end
    assert property (@(posedge clk) disable iff (!rst)
        data_ok2 |-> data_ok1 && (raddr1[OFFSET_W-1 -: WORD_SEL_W] != '1))
        else $error("fetch out: second word without a valid first word");

endmodule

`default_nettype wire

// File: icache_miss_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_miss_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              valid,
    input  logic                              uncached,
    input  logic [icache_pkg::ADDR_W-1:0]     vaddr1,
    input  logic [icache_pkg::ADDR_W-1:0]     vaddr2,
    input  logic [icache_pkg::ADDR_W-1:0]     paddr,
    input  logic                              hit_way0_s2,
    input  logic                              hit_way1_s2,
    input  logic                              ret_valid,
    output logic                              stall,
    output logic [icache_pkg::INDEX_W-1:0]    index_s1,
    output logic [icache_pkg::TAG_W-1:0]      tag_s1,
    output logic [icache_pkg::INDEX_W-1:0]    index_s2,
    output logic [icache_pkg::TAG_W-1:0]      tag_s2,
    output logic [icache_pkg::WORD_SEL_W-1:0] word_s2,
    output logic [icache_pkg::ADDR_W-1:0]     vaddr1_s2,
    output logic [icache_pkg::ADDR_W-1:0]     vaddr2_s2,
    output logic                              valid_s2,
    output logic                              uncached_s2,
    output logic                              hit_s2,
    output logic                              we_way0,
    output logic                              we_way1,
    output logic                              rd_req,
    output logic [7:0]                        rd_len,
    output logic [icache_pkg::ADDR_W-1:0]     rd_addr
);

    import icache_pkg::*;

    logic                miss_s2;
    logic                lru_cur;
    logic [NUM_SETS-1:0] lru;

    // index from the virtual address, tag from the physical one
    assign index_s1 = vaddr1[OFFSET_W +: INDEX_W];
    assign tag_s1   = paddr[ADDR_W-1 -: TAG_W];

    //////////////////////////////////////////////////////////////////////
    // stage-2 request register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            valid_s2    <= 1'b0;
            uncached_s2 <= 1'b0;
        end else if (!stall) begin
            valid_s2    <= valid;
            uncached_s2 <= valid && uncached;
        end
    end

    // address fields, frozen under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            index_s2  <= index_s1;
            tag_s2    <= tag_s1;
            word_s2   <= vaddr1[OFFSET_W-1 -: WORD_SEL_W];
            vaddr1_s2 <= vaddr1;
            vaddr2_s2 <= vaddr2;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // miss detection and refill request
    //////////////////////////////////////////////////////////////////////

    // uncached requests always go to memory
    assign hit_s2  = valid_s2 && !uncached_s2 && (hit_way0_s2 || hit_way1_s2);
    assign miss_s2 = valid_s2 && !hit_s2;

    // pending until the return pulse, which also releases the pipeline
    assign rd_req = miss_s2 && !ret_valid;
    assign stall  = rd_req;

    assign rd_len  = uncached_s2 ? UNCACHED_LEN : REFILL_LEN;
    // whole line for a refill, exact word when uncached
    assign rd_addr = {tag_s2, index_s2,
                      uncached_s2 ? word_s2 : {WORD_SEL_W{1'b0}},
                      {(OFFSET_W - WORD_SEL_W){1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // LRU and way write enables
    //////////////////////////////////////////////////////////////////////

    // bit set means way 0 was used last, so way 1 is the victim
    assign lru_cur = lru[index_s2];
    assign we_way0 = ret_valid && miss_s2 && !uncached_s2 && !lru_cur;
    assign we_way1 = ret_valid && miss_s2 && !uncached_s2 && lru_cur;

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru <= '0;
        end else if (hit_s2) begin
            lru[index_s2] <= hit_way0_s2;
        end else if (we_way0 || we_way1) begin
            lru[index_s2] <= we_way0;
        end
    end

    // a return only answers a request raised in an earlier cycle
    assert property (@(posedge clk) disable iff (!rst)
        ret_valid |-> !rd_req && $past(rd_req))
        else $error("miss ctrl: return without a pending refill request");

    assert property (@(posedge clk) disable iff (!rst)
        !(we_way0 && we_way1))
        else $error("miss ctrl: refill written to both ways");

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    // physical tag above the 4 KB page offset
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 5;
    localparam int WORD_SEL_W = 3;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    // two ways of 128 sets, 32-byte lines
    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = 256;

    // burst length codes on the refill bus
    localparam logic [7:0] REFILL_LEN   = 8'd7;
    localparam logic [7:0] UNCACHED_LEN = 8'd0;

    // banks take the refill line flat and the fetch stage takes it by word
    typedef union packed {
        logic [LINE_W-1:0]                     flat;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } line_t;

endpackage

`default_nettype wire

// File: icache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           stall,
    input  logic [icache_pkg::INDEX_W-1:0] index_s1,
    input  logic [icache_pkg::TAG_W-1:0]   tag_s1,
    input  logic [icache_pkg::INDEX_W-1:0] index_s2,
    input  logic [icache_pkg::TAG_W-1:0]   tag_s2,
    input  logic                           we_way0,
    input  logic                           we_way1,
    output logic                           hit_way0_s2,
    output logic                           hit_way1_s2
);

    import icache_pkg::*;

    logic [1:0] we;
    logic [1:0] hit_s1;

    assign we = {we_way1, we_way0};

    generate
        for (genvar w = 0; w < 2; w++) begin : g_way
            logic [TAG_W-1:0]    tag_mem [NUM_SETS];
            logic [NUM_SETS-1:0] vld;
            logic                fwd;

            // refill writes the tag of the stage-2 request
            always_ff @(posedge clk) begin
                if (we[w]) begin
                    tag_mem[index_s2] <= tag_s2;
                end
            end

            // valid bits only cleared by reset
            always_ff @(posedge clk) begin
                if (!rst) begin
                    vld <= '0;
                end else if (we[w]) begin
                    vld[index_s2] <= 1'b1;
                end
            end

            // write to the same set this cycle replaces the stored entry
            assign fwd       = we[w] && (index_s1 == index_s2);
            assign hit_s1[w] = fwd ? (tag_s1 == tag_s2)
                                   : (vld[index_s1] && (tag_mem[index_s1] == tag_s1));
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // stage-2 hit registers
    //////////////////////////////////////////////////////////////////////

    // held while a miss is pending
    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            hit_way0_s2 <= 1'b0;
            hit_way1_s2 <= 1'b0;
        end else if (!stall) begin
            hit_way0_s2 <= hit_s1[0];
            hit_way1_s2 <= hit_s1[1];
        end
    end

    // refill only on a miss, so no line ever lands in both ways
    assert property (@(posedge clk) disable iff (!rst)
        !(hit_way0_s2 && hit_way1_s2))
        else $error("tag array: line resident in both ways");

endmodule

`default_nettype wire

// File: icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    import icache_pkg::*;

    // about 13 requests of at most 12 cycles each plus reset, wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              valid;
    logic              uncached;
    logic [ADDR_W-1:0] vaddr1;
    logic [ADDR_W-1:0] vaddr2;
    logic [ADDR_W-1:0] paddr;
    logic              ret_valid;
    line_t             ret_data;
    logic              stall;
    logic              data_ok1;
    logic              data_ok2;
    logic [WORD_W-1:0] rdata1;
    logic [WORD_W-1:0] rdata2;
    logic [ADDR_W-1:0] raddr1;
    logic [ADDR_W-1:0] raddr2;
    logic              rd_req;
    logic [7:0]        rd_len;
    logic [ADDR_W-1:0] rd_addr;
    logic              accept;

    // expectations for the request in flight
    logic [ADDR_W-1:0] exp_addr;
    logic [ADDR_W-1:0] exp_rd_addr;
    logic [7:0]        exp_len;
    logic              exp_miss;
    logic              exp_ok2;
    logic              ok_allowed;

    // reference tags and lru bit per set
    bit   [TAG_W-1:0]  model_tag [NUM_SETS][2];
    bit                model_vld [NUM_SETS][2];
    bit                model_lru [NUM_SETS];

    int                errors;
    int                tests_run;
    int                tests_failed;
    int                cycles;

    icache_top dut_i (.*);

    icache_tb_mem mem_i (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_len    (rd_len),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    assign accept = valid && !stall;

    function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        return a ^ 32'hc0de_0000;
    endfunction

    task automatic check_failed(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst)
        rd_req |-> exp_miss && rd_len == exp_len && rd_addr == exp_rd_addr)
        else check_failed("unexpected refill request, or wrong length or address");

    assert property (@(posedge clk) disable iff (!rst)
        accept && exp_miss |=> stall && rd_req)
        else check_failed("miss did not raise stall and rd_req");

    // stall drops with the return, data follows one cycle later
    assert property (@(posedge clk) disable iff (!rst)
        ret_valid |-> !stall ##1 data_ok1)
        else check_failed("no data after the refill return");

    assert property (@(posedge clk) disable iff (!rst)
        accept && !exp_miss && ok_allowed |=> !stall && !rd_req ##1 data_ok1)
        else check_failed("hit not answered right after stage 2");

    assert property (@(posedge clk) disable iff (!rst)
        data_ok1 |-> ok_allowed && raddr1 == exp_addr && raddr2 == exp_addr + 32'd4
                     && rdata1 == word_at(exp_addr))
        else check_failed("first word wrong or not expected");

    assert property (@(posedge clk) disable iff (!rst)
        data_ok1 |-> data_ok2 == exp_ok2)
        else check_failed("data_ok2 does not follow the second-word rule");

    assert property (@(posedge clk) disable iff (!rst)
        data_ok2 |-> rdata2 == word_at(exp_addr + 32'd4))
        else check_failed("second word wrong");

    // a second word that starts a new line reads as zero
    assert property (@(posedge clk) disable iff (!rst)
        data_ok1 && ((exp_addr + 32'd4) & 32'h1f) == 32'd0 |-> rdata2 == '0)
        else check_failed("second word not zero at the start of a new line");

    assert property (@(posedge clk) disable iff (!rst)
        flush |=> !data_ok1 && !data_ok2)
        else check_failed("flush did not drop the data of the request in stage 2");

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // victim is way 1 when the bit says way 0 was used last
    task automatic lookup_model(input logic [ADDR_W-1:0] addr, output logic miss);
        int               idx;
        int               way;
        logic [TAG_W-1:0] tag;
        idx  = int'(addr[OFFSET_W +: INDEX_W]);
        tag  = addr[ADDR_W-1 -: TAG_W];
        miss = 1'b1;
        for (int w = 0; w < 2; w++) begin
            if (model_vld[idx][w] && model_tag[idx][w] == tag) begin
                miss           = 1'b0;
                model_lru[idx] = (w == 0);
            end
        end
        if (miss) begin
            way                 = model_lru[idx] ? 1 : 0;
            model_tag[idx][way] = tag;
            model_vld[idx][way] = 1'b1;
            model_lru[idx]      = (way == 0);
        end
    endtask

    task automatic drive_request(input logic [ADDR_W-1:0] addr, input logic unc,
                                 input logic miss);
        @(posedge clk);
        valid       <= 1'b1;
        uncached    <= unc;
        vaddr1      <= addr;
        vaddr2      <= addr + 32'd4;
        paddr       <= addr;
        exp_addr    <= addr;
        exp_miss    <= miss;
        exp_len     <= unc ? UNCACHED_LEN : REFILL_LEN;
        exp_rd_addr <= unc ? addr : {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        exp_ok2     <= !unc && (addr[OFFSET_W-1 -: WORD_SEL_W] != '1);
    endtask

    // one request at a time, so stall is low at the accepting edge
    task automatic request(input logic [ADDR_W-1:0] addr, input logic unc);
        logic miss;
        miss = 1'b1;
        if (!unc) begin
            lookup_model(addr, miss);
        end
        drive_request(addr, unc, miss);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        while (!data_ok1) begin
            @(negedge clk);
        end
    endtask

    // flush lands in the cycle the hit sits in stage 2
    task automatic flush_hit(input logic [ADDR_W-1:0] addr);
        drive_request(addr, 1'b0, 1'b0);
        ok_allowed <= 1'b0;
        @(posedge clk);
        valid <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (3) @(posedge clk);
        ok_allowed <= 1'b1;
    endtask

    task automatic end_test(input string name, input int errors_before);
        repeat (2) @(posedge clk);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, timeout and test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int mark;
        rst         = 1'b0;
        flush       = 1'b0;
        valid       = 1'b0;
        uncached    = 1'b0;
        vaddr1      = '0;
        vaddr2      = '0;
        paddr       = '0;
        exp_addr    = '0;
        exp_rd_addr = '0;
        exp_len     = '0;
        exp_miss    = 1'b0;
        exp_ok2     = 1'b0;
        ok_allowed  = 1'b1;
        errors      = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;

        mark = errors;
        request(32'h0000_1044, 1'b0);
        end_test("cold miss", mark);

        mark = errors;
        request(32'h0000_1044, 1'b0);
        end_test("repeat hit", mark);

        mark = errors;
        request(32'h0000_105c, 1'b0);
        end_test("end of line", mark);

        // second identical read goes to memory again
        mark = errors;
        request(32'h0000_2208, 1'b1);
        request(32'h0000_2208, 1'b1);
        end_test("uncached", mark);

        // A, B, A, C in set 5, then A stays and B is gone
        mark = errors;
        request(32'h0001_00a0, 1'b0);
        request(32'h0002_00a0, 1'b0);
        request(32'h0001_00a0, 1'b0);
        request(32'h0003_00a4, 1'b0);
        request(32'h0001_00a8, 1'b0);
        request(32'h0002_00a0, 1'b0);
        end_test("lru", mark);

        mark = errors;
        flush_hit(32'h0000_1044);
        end_test("flush", mark);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_tb_mem.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb_mem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_req,
    input  logic [7:0]                    rd_len,
    input  logic [icache_pkg::ADDR_W-1:0] rd_addr,
    output logic                          ret_valid,
    output icache_pkg::line_t             ret_data
);

    import icache_pkg::*;

    logic [31:0]       rng;
    logic              busy;
    logic [2:0]        wait_cnt;
    logic [7:0]        len_q;
    logic [ADDR_W-1:0] addr_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // burst of len+1 words from addr, each word is its address xor c0de_0000
    function automatic line_t build_line(input logic [ADDR_W-1:0] addr,
                                         input logic [7:0]        len);
        line_t line;
        line.flat = '0;
        for (int i = 0; i <= int'(len); i++) begin
            line.words[i] = (addr + ADDR_W'(4 * i)) ^ 32'hc0de_0000;
        end
        return line;
    endfunction

    initial begin
        ret_valid = 1'b0;
        ret_data  = '0;
    end

    // one outstanding read, answered 1 to 6 cycles after it is seen
    always @(posedge clk) begin
        if (!rst) begin
            rng       <= 32'h59a0;
            busy      <= 1'b0;
            ret_valid <= 1'b0;
        end else if (ret_valid) begin
            ret_valid <= 1'b0;
            busy      <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 3'd1) begin
                ret_valid <= 1'b1;
                ret_data  <= build_line(addr_q, len_q);
            end
            wait_cnt <= wait_cnt - 3'd1;
        end else if (rd_req) begin
            busy     <= 1'b1;
            addr_q   <= rd_addr;
            len_q    <= rd_len;
            rng      <= xorshift(rng);
            wait_cnt <= 3'(32'd1 + rng % 32'd6);
        end
    end

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          valid,
    input  logic                          uncached,
    input  logic [icache_pkg::ADDR_W-1:0] vaddr1,
    input  logic [icache_pkg::ADDR_W-1:0] vaddr2,
    input  logic [icache_pkg::ADDR_W-1:0] paddr,
    input  logic                          ret_valid,
    input  icache_pkg::line_t             ret_data,
    output logic                          stall,
    output logic                          data_ok1,
    output logic                          data_ok2,
    output logic [icache_pkg::WORD_W-1:0] rdata1,
    output logic [icache_pkg::WORD_W-1:0] rdata2,
    output logic [icache_pkg::ADDR_W-1:0] raddr1,
    output logic [icache_pkg::ADDR_W-1:0] raddr2,
    output logic                          rd_req,
    output logic [7:0]                    rd_len,
    output logic [icache_pkg::ADDR_W-1:0] rd_addr
);

    import icache_pkg::*;

    // stage-1 lookup
    logic [INDEX_W-1:0]    index_s1;
    logic [TAG_W-1:0]      tag_s1;

    // stage-2 request
    logic [INDEX_W-1:0]    index_s2;
    logic [TAG_W-1:0]      tag_s2;
    logic [WORD_SEL_W-1:0] word_s2;
    logic [ADDR_W-1:0]     vaddr1_s2;
    logic [ADDR_W-1:0]     vaddr2_s2;
    logic                  valid_s2;
    logic                  uncached_s2;
    logic                  hit_s2;
    logic                  hit_way0_s2;
    logic                  hit_way1_s2;
    logic                  we_way0;
    logic                  we_way1;
    line_t                 line_way0_s2;
    line_t                 line_way1_s2;

    icache_miss_ctrl miss_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .valid       (valid),
        .uncached    (uncached),
        .vaddr1      (vaddr1),
        .vaddr2      (vaddr2),
        .paddr       (paddr),
        .hit_way0_s2 (hit_way0_s2),
        .hit_way1_s2 (hit_way1_s2),
        .ret_valid   (ret_valid),
        .stall       (stall),
        .index_s1    (index_s1),
        .tag_s1      (tag_s1),
        .index_s2    (index_s2),
        .tag_s2      (tag_s2),
        .word_s2     (word_s2),
        .vaddr1_s2   (vaddr1_s2),
        .vaddr2_s2   (vaddr2_s2),
        .valid_s2    (valid_s2),
        .uncached_s2 (uncached_s2),
        .hit_s2      (hit_s2),
        .we_way0     (we_way0),
        .we_way1     (we_way1),
        .rd_req      (rd_req),
        .rd_len      (rd_len),
        .rd_addr     (rd_addr)
    );

    icache_tag_array tag_array_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .stall       (stall),
        .index_s1    (index_s1),
        .tag_s1      (tag_s1),
        .index_s2    (index_s2),
        .tag_s2      (tag_s2),
        .we_way0     (we_way0),
        .we_way1     (we_way1),
        .hit_way0_s2 (hit_way0_s2),
        .hit_way1_s2 (hit_way1_s2)
    );

    icache_data_array data_array_i (
        .clk          (clk),
        .stall        (stall),
        .index_s1     (index_s1),
        .index_s2     (index_s2),
        .we_way0      (we_way0),
        .we_way1      (we_way1),
        .ret_data     (ret_data),
        .line_way0_s2 (line_way0_s2),
        .line_way1_s2 (line_way1_s2)
    );

    icache_fetch_out fetch_out_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .valid_s2     (valid_s2),
        .uncached_s2  (uncached_s2),
        .hit_s2       (hit_s2),
        .hit_way0_s2  (hit_way0_s2),
        .hit_way1_s2  (hit_way1_s2),
        .word_s2      (word_s2),
        .vaddr1_s2    (vaddr1_s2),
        .vaddr2_s2    (vaddr2_s2),
        .line_way0_s2 (line_way0_s2),
        .line_way1_s2 (line_way1_s2),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .data_ok1     (data_ok1),
        .data_ok2     (data_ok2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .raddr1       (raddr1),
        .raddr2       (raddr2)
    );

endmodule

`default_nettype wire
